//--- build_sim.sh
#!/usr/bin/env bash
# compile and run the eeprom_ctrl testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
    -f eeprom_ctrl.f \
    --top-module tb_eeprom_ctrl \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./"$BUILD_DIR"/sim_tb > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG_FILE"; then
    echo "testbench reported a failure, see $LOG_FILE"
    exit 1
fi

echo "simulation finished without failures"
exit 0

//--- eeprom_ctrl.f
+incdir+src
src/eeprom_pkg.sv
src/scl_timer.sv
src/i2c_bit_engine.sv
src/eeprom_seq.sv
src/eeprom_ctrl.sv
verification/eeprom_model.sv
verification/tb_eeprom_ctrl.sv

//--- src/eeprom_consts.svh
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// CLK cycles per quarter of an SCL period
`define SCL_QUARTER 5

// device type code, upper nibble of every control byte
`define DEV_CODE 4'b1010

// 2 Kbyte array, three block bits plus a word address
`define ADDR_W 11

`endif

//--- src/eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_consts.svh"

module eeprom_ctrl
    import eeprom_pkg::*;
(
    input  logic               CLK,
    input  logic               RESET,
    input  logic               wr,
    input  logic               rd,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [7:0]         wdata,
    output logic [7:0]         rdata,
    output logic               ack,
    output logic               busy,
    output logic               nack_err,
    output logic               scl,
    output logic               sda_low,
    input  logic               sda_in
);

    logic       tick;
    logic [1:0] phase;
    logic       eng_busy;   // also runs the SCL timer
    bus_cmd_t   cmd;
    logic       cmd_valid;
    logic [7:0] tx_byte;
    logic       ack_out;
    logic       cmd_done;
    logic [7:0] rx_byte;
    logic       ack_in;

    scl_timer u_timer
    (
        .CLK   (CLK),
        .RESET (RESET),
        .run   (eng_busy),
        .tick  (tick),
        .phase (phase)
    );

    i2c_bit_engine u_engine
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .tx_byte   (tx_byte),
        .ack_out   (ack_out),
        .tick      (tick),
        .phase     (phase),
        .sda_in    (sda_in),
        .scl       (scl),
        .sda_low   (sda_low),
        .busy      (eng_busy),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .ack_in    (ack_in)
    );

    eeprom_seq u_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .ack_in    (ack_in),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .tx_byte   (tx_byte),
        .ack_out   (ack_out),
        .busy      (busy),
        .ack       (ack),
        .rdata     (rdata),
        .nack_err  (nack_err)
    );

endmodule

`default_nettype wire

//--- src/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // sequencer states, one per bus primitive plus idle and done
    typedef enum logic [3:0]
    {
        ST_IDLE,
        ST_START,
        ST_CTRL_WR,
        ST_ADDR,
        ST_DATA_WR,
        ST_RSTART,   // repeated start before the read control byte
        ST_CTRL_RD,
        ST_DATA_RD,
        ST_STOP,
        ST_DONE
    } seq_state_t;

    // primitives the bit engine can run
    typedef enum logic [2:0]
    {
        CMD_NONE,
        CMD_START,
        CMD_STOP,
        CMD_WR_BYTE,
        CMD_RD_BYTE
    } bus_cmd_t;

endpackage

`default_nettype wire

//--- src/eeprom_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_consts.svh"

module eeprom_seq
    import eeprom_pkg::*;
(
    input  logic               CLK,
    input  logic               RESET,
    input  logic               wr,
    input  logic               rd,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [7:0]         wdata,
    input  logic               cmd_done,
    input  logic [7:0]         rx_byte,
    input  logic               ack_in,
    output bus_cmd_t           cmd,
    output logic               cmd_valid,
    output logic [7:0]         tx_byte,
    output logic               ack_out,
    output logic               busy,
    output logic               ack,
    output logic [7:0]         rdata,
    output logic               nack_err
);

    seq_state_t         state;
    seq_state_t         next_state;
    bus_cmd_t           next_cmd;
    logic [7:0]         next_tx;
    logic               accept;
    logic               advance;
    logic               op_rd;
    logic [`ADDR_W-1:0] addr_q;
    logic [7:0]         data_q;

    assign accept  = (state == ST_IDLE || state == ST_DONE) && (wr || rd);
    assign advance = (next_state != state);

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE, ST_DONE: next_state = accept ? ST_START : ST_IDLE;
            ST_START:   if (cmd_done) next_state = ST_CTRL_WR;
            ST_CTRL_WR: if (cmd_done) next_state = ST_ADDR;
            ST_ADDR:    if (cmd_done) next_state = op_rd ? ST_RSTART : ST_DATA_WR;
            ST_DATA_WR: if (cmd_done) next_state = ST_STOP;
            ST_RSTART:  if (cmd_done) next_state = ST_CTRL_RD;
            ST_CTRL_RD: if (cmd_done) next_state = ST_DATA_RD;
            ST_DATA_RD: if (cmd_done) next_state = ST_STOP;
            ST_STOP:    if (cmd_done) next_state = ST_DONE;
            default:    next_state = ST_IDLE;
        endcase
    end

    // primitive and byte that go with the state being entered
    always_comb
    begin
        next_cmd = CMD_NONE;
        next_tx  = 8'h00;
        case (next_state)
            ST_START, ST_RSTART: next_cmd = CMD_START;
            ST_CTRL_WR:
            begin
                next_cmd = CMD_WR_BYTE;
                next_tx  = {`DEV_CODE, addr_q[`ADDR_W-1:8], 1'b0};
            end
            ST_ADDR:
            begin
                next_cmd = CMD_WR_BYTE;
                next_tx  = addr_q[7:0];
            end
            ST_DATA_WR:
            begin
                next_cmd = CMD_WR_BYTE;
                next_tx  = data_q;
            end
            ST_CTRL_RD:
            begin
                next_cmd = CMD_WR_BYTE;
                next_tx  = {`DEV_CODE, addr_q[`ADDR_W-1:8], 1'b1};
            end
            ST_DATA_RD: next_cmd = CMD_RD_BYTE;
            ST_STOP:    next_cmd = CMD_STOP;
            default:    next_cmd = CMD_NONE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= ST_IDLE;
            cmd       <= CMD_NONE;
            cmd_valid <= 1'b0;
            busy      <= 1'b0;
            ack       <= 1'b0;
            nack_err  <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            cmd_valid <= advance && (next_cmd != CMD_NONE);
            ack       <= (next_state == ST_DONE);
            busy      <= (next_state != ST_IDLE) && (next_state != ST_DONE);
            if (advance)
                cmd <= next_cmd;
            if (accept)
                nack_err <= 1'b0;
            else if (cmd_done && cmd == CMD_WR_BYTE && !ack_in)
                nack_err <= 1'b1;   // keep going to stop so the bus is released
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            op_rd  <= !wr;  // write wins if both pulse
            addr_q <= addr;
            data_q <= wdata;
        end
        if (advance && next_cmd != CMD_NONE)
        begin
            tx_byte <= next_tx;
            ack_out <= 1'b0;    // single read ends with master nack
        end
        if (state == ST_DATA_RD && cmd_done)
            rdata <= rx_byte;
    end

    // ack only as the one-cycle close of a stop condition
    property p_ack_after_stop;
        @(posedge CLK) disable iff (RESET)
            ack |-> (state == ST_DONE && $past(state) == ST_STOP);
    endproperty

    a_ack_after_stop : assert property (p_ack_after_stop)
        else $error("eeprom_seq: ack outside done");

    property p_ack_pulse;
        @(posedge CLK) disable iff (RESET)
            ack |=> !ack;
    endproperty

    a_ack_pulse : assert property (p_ack_pulse)
        else $error("eeprom_seq: ack longer than one cycle");

endmodule

`default_nettype wire

//--- src/i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  bus_cmd_t   cmd,
    input  logic       cmd_valid,
    input  logic [7:0] tx_byte,
    input  logic       ack_out,
    input  logic       tick,
    input  logic [1:0] phase,
    input  logic       sda_in,
    output logic       scl,
    output logic       sda_low,
    output logic       busy,
    output logic       cmd_done,
    output logic [7:0] rx_byte,
    output logic       ack_in
);

    bus_cmd_t   cur_cmd;
    logic [7:0] shreg;
    logic [3:0] bit_cnt;
    logic       last_bit;
    logic       next_sda_low;

    // start and stop are a single SCL period, bytes run to the ack slot
    assign last_bit = (cur_cmd == CMD_START) || (cur_cmd == CMD_STOP) || (bit_cnt == 4'd8);

    assign rx_byte = shreg;

    // what SDA does during the low quarter of the current period
    always_comb
    begin
        case (cur_cmd)
            CMD_START:   next_sda_low = 1'b0;           // released, may follow a byte
            CMD_STOP:    next_sda_low = 1'b1;           // held low before the rising edge
            CMD_WR_BYTE: next_sda_low = (bit_cnt == 4'd8) ? 1'b0 : !shreg[7];
            CMD_RD_BYTE: next_sda_low = (bit_cnt == 4'd8) ? ack_out : 1'b0;
            default:     next_sda_low = sda_low;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl      <= 1'b1;
            sda_low  <= 1'b0;
            busy     <= 1'b0;
            cmd_done <= 1'b0;
            cur_cmd  <= CMD_NONE;
            bit_cnt  <= 4'd0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (!busy)
            begin
                if (cmd_valid && (cmd != CMD_NONE))
                begin
                    busy    <= 1'b1;
                    cur_cmd <= cmd;
                    bit_cnt <= 4'd0;
                end
            end
            else if (tick)
            begin
                case (phase)
                    2'd0: sda_low <= next_sda_low;
                    2'd1: scl <= 1'b1;
                    2'd2:
                    begin
                        if (cur_cmd == CMD_START)
                            sda_low <= 1'b1;    // SDA falls, SCL high
                        else if (cur_cmd == CMD_STOP)
                            sda_low <= 1'b0;    // SDA rises, SCL high
                    end
                    default:
                    begin
                        scl     <= (cur_cmd == CMD_STOP);  // bus stays free after stop
                        bit_cnt <= bit_cnt + 4'd1;
                        if (last_bit)
                        begin
                            busy     <= 1'b0;
                            cmd_done <= 1'b1;
                            cur_cmd  <= CMD_NONE;
                        end
                    end
                endcase
            end
        end
    end

    // shift register and sampled acknowledge
    always_ff @(posedge CLK)
    begin
        if (!busy && cmd_valid)
            shreg <= tx_byte;
        else if (busy && tick)
        begin
            if (phase == 2'd2 && cur_cmd == CMD_RD_BYTE && !last_bit)
                shreg <= {shreg[6:0], sda_in};  // msb first
            if (phase == 2'd3 && cur_cmd == CMD_WR_BYTE && !last_bit)
                shreg <= {shreg[6:0], 1'b0};
            if (phase == 2'd2 && cur_cmd == CMD_WR_BYTE && last_bit)
                ack_in <= !sda_in;              // slave pulls low to ack
        end
    end

    // data may only move under a high SCL as a start or stop condition
    property p_sda_stable_high;
        @(posedge CLK) disable iff (RESET)
            (scl && $changed(sda_low)) |-> (cur_cmd == CMD_START || cur_cmd == CMD_STOP);
    endproperty

    a_sda_stable_high : assert property (p_sda_stable_high)
        else $error("i2c_bit_engine: SDA moved while SCL high outside start/stop");

    property p_done_pulse;
        @(posedge CLK) disable iff (RESET)
            cmd_done |=> !cmd_done;
    endproperty

    a_done_pulse : assert property (p_done_pulse)
        else $error("i2c_bit_engine: cmd_done longer than one cycle");

endmodule

`default_nettype wire

//--- src/scl_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_consts.svh"

module scl_timer
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       run,
    output logic       tick,
    output logic [1:0] phase
);

    localparam int CNT_W = (`SCL_QUARTER > 1) ? $clog2(`SCL_QUARTER) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SCL_QUARTER - 1);

    logic [CNT_W-1:0] cnt;

    // last cycle of the current quarter
    assign tick = run && (cnt == CNT_LAST);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cnt   <= '0;
            phase <= 2'd0;
        end
        else if (!run)
        begin
            // parked in phase 0 until the engine takes a command
            cnt   <= '0;
            phase <= 2'd0;
        end
        else if (tick)
        begin
            cnt   <= '0;
            phase <= phase + 2'd1;  // wraps 3 -> 0
        end
        else
        begin
            cnt <= cnt + CNT_W'(1);
        end
    end

    // phase only moves at the end of a quarter, or back to 0 when stopped
    property p_phase_on_tick;
        @(posedge CLK) disable iff (RESET)
            $changed(phase) |-> ($past(tick) || !$past(run));
    endproperty

    a_phase_on_tick : assert property (p_phase_on_tick)
        else $error("scl_timer: phase moved without a tick");

endmodule

`default_nettype wire

//--- verification/eeprom_model.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"
`default_nettype none

module eeprom_model
(
    input  logic scl,
    input  logic sda,
    input  logic enable,
    output logic sda_low
);

    localparam int M_IDLE  = 0;
    localparam int M_CTRL  = 1;
    localparam int M_ADDR  = 2;
    localparam int M_WDATA = 3;
    localparam int M_RDATA = 4;

    logic [7:0] mem [0:2047];
    int         mode;
    int         bit_cnt;
    logic [7:0] shreg;
    logic [7:0] out_byte;
    logic [2:0] block;
    logic [7:0] word;
    logic       read_op;
    logic       master_ack;
    logic       scl_q;
    logic       sda_q;

    // eighth bit is in, decide on the acknowledge
    task automatic end_of_byte();
        sda_low = 1'b0;
        if (!enable)
            mode = M_IDLE;
        else
        begin
            case (mode)
                M_CTRL:
                begin
                    if (shreg[7:4] == `DEV_CODE)
                    begin
                        block   = shreg[3:1];
                        read_op = shreg[0];
                        sda_low = 1'b1;
                    end
                    else
                        mode = M_IDLE;  // not our device type
                end
                M_ADDR:
                begin
                    word    = shreg;
                    sda_low = 1'b1;
                end
                M_WDATA:
                begin
                    mem[{block, word}] = shreg;
                    word[3:0]          = word[3:0] + 4'd1;  // rolls within a 16 byte page
                    sda_low            = 1'b1;
                end
                default: ;  // read byte, master answers
            endcase
        end
    endtask

    // ack clock is over
    task automatic after_ack();
        sda_low = 1'b0;
        case (mode)
            M_CTRL:  mode = read_op ? M_RDATA : M_ADDR;
            M_ADDR:  mode = M_WDATA;
            M_RDATA:
            begin
                if (master_ack)
                    word = word + 8'd1;
                else
                    mode = M_IDLE;
            end
            default: ;
        endcase
        if (mode == M_RDATA)
        begin
            out_byte = mem[{block, word}];
            sda_low  = !out_byte[7];
        end
    endtask

    initial
    begin
        logic [10:0] a;
        int          i;
        for (i = 0; i < 2048; i++)
        begin
            a      = 11'(i);
            mem[a] = a[7:0] ^ {a[10:8], a[10:8], 2'b01};
        end
        mode       = M_IDLE;
        bit_cnt    = 0;
        shreg      = 8'h00;
        out_byte   = 8'hFF;
        block      = 3'd0;
        word       = 8'h00;
        read_op    = 1'b0;
        master_ack = 1'b0;
        sda_low    = 1'b0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        forever
        begin
            @(scl or sda);
            if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
            begin
                mode    = M_CTRL;   // start or repeated start
                bit_cnt = -1;       // scl fall that closes the start
                sda_low = 1'b0;
            end
            else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
            begin
                mode    = M_IDLE;   // stop
                sda_low = 1'b0;
            end
            else if (mode != M_IDLE && scl_q !== 1'b1 && scl === 1'b1)
            begin
                if (bit_cnt < 8)
                    shreg = {shreg[6:0], sda};
                else
                    master_ack = !sda;
            end
            else if (mode != M_IDLE && scl_q === 1'b1 && scl === 1'b0)
            begin
                if (bit_cnt < 7)
                begin
                    bit_cnt++;
                    if (mode == M_RDATA)
                    begin
                        out_byte = {out_byte[6:0], 1'b1};
                        sda_low  = !out_byte[7];
                    end
                end
                else if (bit_cnt == 7)
                begin
                    bit_cnt = 8;
                    end_of_byte();
                end
                else
                begin
                    bit_cnt = 0;
                    after_ack();
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"
`default_nettype none

module tb_eeprom_ctrl;

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int RAND_LOOPS  = 16;
    // host operations over all tests, a few spare
    localparam int NUM_OPS        = 2 + 2 * RAND_LOOPS + 3 + 2 + 4;
    // longest op is 40 SCL periods of four quarters, doubled
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40 * 4 * `SCL_QUARTER * 2;

    logic               CLK;
    logic               RESET;
    logic               wr;
    logic               rd;
    logic [`ADDR_W-1:0] addr;
    logic [7:0]         wdata;
    logic [7:0]         rdata;
    logic               ack;
    logic               busy;
    logic               nack_err;
    logic               scl;
    logic               sda_low;
    logic               model_sda_low;
    logic               model_enable;
    wire                sda;

    integer     seed;
    int         error_count = 0;
    int         check_count = 0;
    int         test_count  = 0;
    int         ack_count   = 0;
    int         cycle_count = 0;
    logic [7:0] last_rdata;
    logic       last_nack;

    assign sda = !(sda_low || model_sda_low);  // open drain wired-AND

    eeprom_ctrl UUT
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .ack      (ack),
        .busy     (busy),
        .nack_err (nack_err),
        .scl      (scl),
        .sda_low  (sda_low),
        .sda_in   (sda)
    );

    eeprom_model slave
    (
        .scl     (scl),
        .sda     (sda),
        .enable  (model_enable),
        .sda_low (model_sda_low)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    always @(negedge CLK)
    begin
        if (ack === 1'b1)
            ack_count++;
    end

    initial
    begin
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("error: time %0t signal %s got %0h expected %0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        $display("test %-14s done, %0d errors", name, error_count - errs_before);
    endtask

    // one-cycle request pulse
    task automatic issue_request(input logic is_write, input logic [`ADDR_W-1:0] a,
                                 input logic [7:0] d);
        @(posedge CLK);
        #DRIVE_DELAY;
        wr    = is_write;
        rd    = !is_write;
        addr  = a;
        wdata = d;
        @(posedge CLK);
        #DRIVE_DELAY;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_for_ack();
        @(negedge CLK);
        check_value("busy", 32'(busy), 32'd1);
        while (ack !== 1'b1)
            @(negedge CLK);
        check_value("busy", 32'(busy), 32'd0);  // falls with ack
        last_rdata = rdata;
        last_nack  = nack_err;
        @(negedge CLK);
        check_value("ack", 32'(ack), 32'd0);
    endtask

    task automatic write_byte(input logic [`ADDR_W-1:0] a, input logic [7:0] d);
        issue_request(1'b1, a, d);
        wait_for_ack();
    endtask

    task automatic read_byte(input logic [`ADDR_W-1:0] a);
        issue_request(1'b0, a, 8'h00);
        wait_for_ack();
    endtask

    task automatic check_released();
        check_value("scl", 32'(scl), 32'd1);
        check_value("sda_low", 32'(sda_low), 32'd0);
        check_value("sda", 32'(sda), 32'd1);
    endtask

    task automatic test_reset_state();
        int errs;
        errs = error_count;
        @(negedge CLK);
        check_released();
        check_value("busy", 32'(busy), 32'd0);
        check_value("ack", 32'(ack), 32'd0);
        check_value("nack_err", 32'(nack_err), 32'd0);
        report_test("reset_state", errs);
    endtask

    task automatic test_write_read();
        logic [`ADDR_W-1:0] a;
        logic [7:0]         d;
        int                 errs;
        errs = error_count;
        a    = 11'h5A3;
        d    = 8'hC6;
        write_byte(a, d);
        check_value("nack_err", 32'(last_nack), 32'd0);
        check_value("mem", 32'(slave.mem[a]), 32'(d));
        read_byte(a);
        check_value("nack_err", 32'(last_nack), 32'd0);
        check_value("rdata", 32'(last_rdata), 32'(d));
        report_test("write_read", errs);
    endtask

    task automatic test_random_blocks();
        logic [`ADDR_W-1:0] addr_list [RAND_LOOPS];
        logic [7:0]         data_list [RAND_LOOPS];
        logic [7:0]         word;
        int                 i;
        int                 j;
        int                 errs;
        errs = error_count;
        for (i = 0; i < RAND_LOOPS; i++)
        begin
            word         = 8'($random(seed));
            word[7]      = (i >= 8);    // two words per block, never equal
            addr_list[i] = {3'(i % 8), word};
            data_list[i] = 8'($random(seed));
            write_byte(addr_list[i], data_list[i]);
            check_value("nack_err", 32'(last_nack), 32'd0);
        end
        for (i = 0; i < RAND_LOOPS; i++)
        begin
            j = (i * 5 + 3) % RAND_LOOPS;  // stride 5 hits every slot once
            read_byte(addr_list[j]);
            check_value("nack_err", 32'(last_nack), 32'd0);
            check_value("rdata", 32'(last_rdata), 32'(data_list[j]));
        end
        report_test("random_blocks", errs);
    endtask

    task automatic test_no_ack();
        logic [`ADDR_W-1:0] a;
        logic [7:0]         old_byte;
        int                 errs;
        errs         = error_count;
        a            = 11'h317;
        old_byte     = slave.mem[a];
        model_enable = 1'b0;
        write_byte(a, ~old_byte);
        check_value("nack_err", 32'(last_nack), 32'd1);
        check_released();
        read_byte(a);
        check_value("nack_err", 32'(last_nack), 32'd1);
        check_released();
        model_enable = 1'b1;
        write_byte(a, 8'h3C);
        check_value("nack_err", 32'(last_nack), 32'd0);
        check_value("mem", 32'(slave.mem[a]), 32'h3C);
        report_test("no_ack", errs);
    endtask

    task automatic test_busy_ignored();
        logic [`ADDR_W-1:0] first_addr;
        logic [`ADDR_W-1:0] second_addr;
        logic [7:0]         first_data;
        logic [7:0]         second_old;
        logic               busy_seen;
        int                 acks_before;
        int                 errs;
        errs        = error_count;
        first_addr  = 11'h2C4;
        second_addr = 11'h6D1;
        first_data  = 8'($random(seed));
        second_old  = slave.mem[second_addr];
        acks_before = ack_count;
        issue_request(1'b1, first_addr, first_data);
        repeat (10) @(negedge CLK);
        check_value("busy", 32'(busy), 32'd1);
        issue_request(1'b1, second_addr, ~second_old);
        wait_for_ack();
        busy_seen = 1'b0;
        repeat (4 * 4 * `SCL_QUARTER)
        begin
            @(negedge CLK);
            if (busy === 1'b1)
                busy_seen = 1'b1;
        end
        check_value("busy", 32'(busy_seen), 32'd0);
        check_value("ack_count", 32'(ack_count - acks_before), 32'd1);
        check_value("mem_first", 32'(slave.mem[first_addr]), 32'(first_data));
        check_value("mem_second", 32'(slave.mem[second_addr]), 32'(second_old));
        report_test("busy_ignored", errs);
    endtask

    initial
    begin
        seed         = 79348;
        RESET        = 1'b1;
        wr           = 1'b0;
        rd           = 1'b0;
        addr         = '0;
        wdata        = 8'h00;
        model_enable = 1'b1;
        last_rdata   = 8'h00;
        last_nack    = 1'b0;
        repeat (4) @(posedge CLK);
        #DRIVE_DELAY;
        RESET = 1'b0;

        test_reset_state();
        test_write_read();
        test_random_blocks();
        test_no_ack();
        test_busy_ignored();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
